//--- src.f
hw/usb_rx_pkg.sv
hw/usb_packet_decoder.sv
hw/usb_token_filter.sv
hw/usb_rx_regs.sv
hw/usb_rx_top.sv
tb/usb_rx_sva.sv
tb/usb_rx_tb.sv

//--- Makefile
# Verilator build and run of the USB receive front end testbench

VERILATOR ?= verilator
TOP       ?= usb_rx_tb
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := *** TEST FAILED ***

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM)
	@status=0; ./$(SIM) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/usb_rx_tb.sv
`timescale 1ns/1ns

// Testbench for the USB receive front end
// Packets go in on the PHY stream, filtered events are checked at the top level
module usb_rx_tb
  import usb_rx_pkg::*;
();

  localparam int wb_timeout    = 8;
  localparam int pkt_timeout   = 100;
  // Pipeline latency is fixed, so a short idle gap covers late strobes
  localparam int settle_cycles = 6;

  // Expected event kinds, upper nibble of an event word
  localparam logic [3:0] ev_tok  = 4'd1;
  localparam logic [3:0] ev_data = 4'd2;
  localparam logic [3:0] ev_byte = 4'd3;
  localparam logic [3:0] ev_hsk  = 4'd4;
  localparam logic [3:0] ev_crc  = 4'd5;

  logic        clock;
  logic        reset;
  logic        ulpi_tvalid;
  logic        ulpi_tlast;
  logic [7:0]  ulpi_tdata;
  logic        ulpi_tready;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        tok_valid;
  logic [1:0]  tok_type;
  logic [3:0]  tok_endp;
  logic        data_valid;
  logic [1:0]  data_type;
  logic        data_tvalid;
  logic        data_tlast;
  logic [7:0]  data_tdata;
  logic        hsk_valid;
  logic [1:0]  hsk_type;
  logic        crc_err;

  // Packet under construction and the events it should produce
  logic [7:0]  pkt[$];
  logic [15:0] expected[$];
  logic [31:0] rng;

  // Reference copy of the register block and the data gate
  logic [6:0]  ref_addr;
  logic        ref_enable;
  logic        ref_armed;
  logic [10:0] ref_frame;
  logic [15:0] ref_sof_count;
  logic [15:0] ref_crc_errs;

  usb_rx_top u_dut (
    .clock         (clock),
    .reset         (reset),
    .ulpi_tvalid_i (ulpi_tvalid),
    .ulpi_tlast_i  (ulpi_tlast),
    .ulpi_tdata_i  (ulpi_tdata),
    .ulpi_tready_o (ulpi_tready),
    .wb_cyc_i      (wb_cyc),
    .wb_stb_i      (wb_stb),
    .wb_we_i       (wb_we),
    .wb_adr_i      (wb_adr),
    .wb_dat_i      (wb_dat_w),
    .wb_dat_o      (wb_dat_r),
    .wb_ack_o      (wb_ack),
    .tok_valid_o   (tok_valid),
    .tok_type_o    (tok_type),
    .tok_endp_o    (tok_endp),
    .data_valid_o  (data_valid),
    .data_type_o   (data_type),
    .data_tvalid_o (data_tvalid),
    .data_tlast_o  (data_tlast),
    .data_tdata_o  (data_tdata),
    .hsk_valid_o   (hsk_valid),
    .hsk_type_o    (hsk_type),
    .crc_err_o     (crc_err)
  );

  always #5 clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] reverse_byte(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7-i];
    end
    return r;
  endfunction

  // Expected top-level events for the packet in pkt
  function automatic void predict(input logic corrupt);
    logic [3:0]  pid;
    logic [10:0] field;
    logic        last_byte;
    int          n;
    n   = pkt.size();
    pid = pkt[0][3:0];
    // A byte without a valid complement is not a PID at all
    if (pkt[0][7:4] == ~pid) begin
      if (pid inside {pid_ack, pid_nak, pid_stall, pid_nyet}) begin
        expected.push_back({ev_hsk, 10'd0, pid[3:2]});
      end else if (pid inside {pid_sof, pid_out, pid_in, pid_setup}) begin
        field = {pkt[2][2:0], pkt[1]};
        if (corrupt) begin
          expected.push_back({ev_crc, 12'd0});
          ref_crc_errs++;
        end else if (pid == pid_sof) begin
          ref_frame = field;
          ref_sof_count++;
          ref_armed = 1'b0;
        end else if (ref_enable && field[6:0] == ref_addr) begin
          expected.push_back({ev_tok, 6'd0, pid[3:2], field[10:7]});
          ref_armed = pid == pid_out || pid == pid_setup;
        end else begin
          ref_armed = 1'b0;
        end
      end else begin
        // Data packet, payload sits between the PID and the two CRC bytes
        if (ref_armed) begin
          expected.push_back({ev_data, 10'd0, pid[3:2]});
          for (int i = 1; i <= n - 3; i++) begin
            last_byte = i == n - 3;
            expected.push_back({ev_byte, 3'd0, last_byte, pkt[i]});
          end
        end
        if (corrupt) begin
          expected.push_back({ev_crc, 12'd0});
          ref_crc_errs++;
        end
      end
    end
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      fail_stop(msg);
    end
  endtask

  // One Wishbone classic cycle, ack must follow the request by one cycle
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int cycles;
    @(negedge clock);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    cycles   = 0;
    while (!wb_ack && cycles < wb_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (!wb_ack) begin
      fail_stop("Timeout: the register block never acknowledged the bus cycle");
    end else begin
      check_value(32'(cycles), 32'd1, "ack delay in cycles");
      rdat   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clock);
      check_value({31'd0, wb_ack}, 32'd0, "ack one cycle later");
    end
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    wb_access(1'b1, adr, data, ignored);
    if (adr == reg_ctrl) begin
      ref_addr   = data[6:0];
      ref_enable = data[7];
    end
    // Any write clears a counter
    if (adr == reg_crc_errs) begin
      ref_crc_errs = 16'd0;
    end
    if (adr == reg_sof_count) begin
      ref_sof_count = 16'd0;
    end
  endtask

  task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp, input string what);
    logic [31:0] rdat;
    wb_access(1'b0, adr, 32'd0, rdat);
    check_value(rdat, exp, what);
  endtask

  task automatic check_registers();
    wb_read_check(reg_ctrl, {24'd0, ref_enable, ref_addr}, "control register");
    wb_read_check(reg_frame, {21'd0, ref_frame}, "frame register");
    wb_read_check(reg_crc_errs, {16'd0, ref_crc_errs}, "CRC error count");
    wb_read_check(reg_sof_count, {16'd0, ref_sof_count}, "SOF count");
  endtask

  // Wait until every expected event has been seen, then leave an idle gap
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (expected.size() != 0 && cycles < pkt_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (expected.size() != 0) begin
      fail_stop("Timeout: expected filter events did not arrive");
    end else begin
      repeat (settle_cycles) @(negedge clock);
    end
  endtask

  task automatic send_packet(input logic corrupt);
    predict(corrupt);
    for (int i = 0; i < pkt.size(); i++) begin
      @(negedge clock);
      ulpi_tvalid = 1'b1;
      ulpi_tdata  = pkt[i];
      ulpi_tlast  = i == pkt.size() - 1;
    end
    @(negedge clock);
    ulpi_tvalid = 1'b0;
    ulpi_tlast  = 1'b0;
    wait_drained();
  endtask

  // Token or SOF, CRC5 lands in bits 7:3 of the second byte
  task automatic token_packet(input logic [3:0] pid, input logic [10:0] field, input logic corrupt);
    logic [4:0] crc;
    crc = crc5(field);
    if (corrupt) begin
      crc = crc ^ 5'b00100;
    end
    pkt.delete();
    pkt.push_back({~pid, pid});
    pkt.push_back(field[7:0]);
    pkt.push_back({crc, field[10:8]});
    send_packet(corrupt);
  endtask

  task automatic data_packet(input logic [3:0] pid, input int len, input logic corrupt);
    logic [15:0] crc;
    logic [15:0] inv;
    logic [7:0]  b;
    pkt.delete();
    pkt.push_back({~pid, pid});
    crc = crc16_init;
    for (int i = 0; i < len; i++) begin
      rng = xorshift32(rng);
      b   = rng[15:8];
      crc = crc16(b, crc);
      pkt.push_back(b);
    end
    // Inverted CRC, register bit 15 first on the wire
    inv = ~crc;
    if (corrupt) begin
      inv[0] = ~inv[0];
    end
    pkt.push_back(reverse_byte(inv[15:8]));
    pkt.push_back(reverse_byte(inv[7:0]));
    send_packet(corrupt);
  endtask

  // Single byte with last set, a handshake or a broken PID
  task automatic single_byte_packet(input logic [7:0] b);
    pkt.delete();
    pkt.push_back(b);
    send_packet(1'b0);
  endtask

  task automatic compare_event(input logic [15:0] seen, input string what);
    logic [15:0] exp;
    if (expected.size() == 0) begin
      fail_stop($sformatf("Unexpected %s at %0t ns, event word %h", what, $time, seen));
    end else begin
      exp = expected.pop_front();
      check_value({16'd0, seen}, {16'd0, exp}, what);
    end
  endtask

  // Compare every top-level strobe with the head of the queue
  always @(negedge clock) begin
    if (!reset) begin
      if (tok_valid) begin
        compare_event({ev_tok, 6'd0, tok_type, tok_endp}, "token event");
      end
      if (data_valid) begin
        compare_event({ev_data, 10'd0, data_type}, "data packet start");
      end
      if (data_tvalid) begin
        compare_event({ev_byte, 3'd0, data_tlast, data_tdata}, "payload byte");
      end
      if (hsk_valid) begin
        compare_event({ev_hsk, 10'd0, hsk_type}, "handshake event");
      end
      if (crc_err) begin
        compare_event({ev_crc, 12'd0}, "CRC error");
      end
    end
  end

  initial begin
    int len;
    clock         = 1'b0;
    reset         = 1'b1;
    ulpi_tvalid   = 1'b0;
    ulpi_tlast    = 1'b0;
    ulpi_tdata    = 8'd0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = 2'd0;
    wb_dat_w      = 32'd0;
    rng           = 32'h133d_4d8e;
    ref_addr      = 7'd0;
    ref_enable    = 1'b0;
    ref_armed     = 1'b0;
    ref_frame     = 11'd0;
    ref_sof_count = 16'd0;
    ref_crc_errs  = 16'd0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_value({31'd0, ulpi_tready}, 32'd1, "PHY ready");
    check_registers();

    // Program address and enable, read back
    wb_write(reg_ctrl, {24'd0, 1'b1, 7'h2a});
    check_registers();

    // Good SOF loads the frame, broken CRC5 only counts an error
    token_packet(pid_sof, 11'h5a3, 1'b0);
    check_registers();
    token_packet(pid_sof, 11'h1c4, 1'b1);
    check_registers();

    // Tokens for this device with random endpoints
    rng = xorshift32(rng);
    token_packet(pid_out, {rng[3:0], ref_addr}, 1'b0);
    token_packet(pid_in, {rng[7:4], ref_addr}, 1'b0);
    token_packet(pid_setup, {rng[11:8], ref_addr}, 1'b0);
    // Other address, then the right address while disabled
    token_packet(pid_in, {4'd1, ref_addr ^ 7'h01}, 1'b0);
    wb_write(reg_ctrl, {24'd0, 1'b0, ref_addr});
    token_packet(pid_out, {4'd2, ref_addr}, 1'b0);
    wb_write(reg_ctrl, {24'd0, 1'b1, ref_addr});

    // OUT or SETUP then data, lengths 0, 64 and random
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      len = (i == 0) ? 0 : (i == 1) ? 64 : int'(rng % 32'd65);
      token_packet(i[0] ? pid_setup : pid_out, {rng[27:24], ref_addr}, 1'b0);
      data_packet(i[1] ? pid_data1 : pid_data0, len, 1'b0);
    end

    // Data after IN is dropped
    token_packet(pid_in, {4'd3, ref_addr}, 1'b0);
    data_packet(pid_data0, 5, 1'b0);
    // Accepted OUT, then a filtered token closes the gate again
    token_packet(pid_out, {4'd3, ref_addr}, 1'b0);
    token_packet(pid_out, {4'd3, ref_addr ^ 7'h10}, 1'b0);
    data_packet(pid_data0, 7, 1'b0);
    // An SOF between SETUP and data closes it too
    token_packet(pid_setup, {4'd5, ref_addr}, 1'b0);
    token_packet(pid_sof, 11'h2e7, 1'b0);
    data_packet(pid_data0, 3, 1'b0);
    // Broken CRC16 after an accepted OUT
    token_packet(pid_out, {4'd4, ref_addr}, 1'b0);
    data_packet(pid_data1, 12, 1'b1);
    check_registers();
    wb_write(reg_crc_errs, 32'hffff_ffff);
    check_registers();

    // Handshakes, then bytes that fail the complement check
    single_byte_packet({~pid_ack, pid_ack});
    single_byte_packet({~pid_nak, pid_nak});
    single_byte_packet({~pid_stall, pid_stall});
    single_byte_packet({~pid_nyet, pid_nyet});
    single_byte_packet(8'hc2);
    single_byte_packet({pid_ack, pid_ack});
    check_registers();

    if (expected.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_stop("Expected filter events are still outstanding at the end of the run");
    end
  end

endmodule

//--- tb/usb_rx_sva.sv
`timescale 1ns/1ns

// Output checks on the token filter
module usb_rx_sva (
  input logic clock,
  input logic reset,
  input logic tok_valid_i,
  input logic data_valid_i,
  input logic data_tvalid_i
);

  // Open from a data packet start until the next token
  logic data_open;

  always_ff @(posedge clock) begin
    if (reset || tok_valid_i) begin
      data_open <= 1'b0;
    end else if (data_valid_i) begin
      data_open <= 1'b1;
    end
  end

  tok_data_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(tok_valid_i && data_valid_i)
  ) else $error("token and data start strobes high together");

  payload_after_start: assert property (
    @(posedge clock) disable iff (reset) data_tvalid_i |-> data_open
  ) else $error("payload byte without a preceding data start");

endmodule

bind usb_token_filter usb_rx_sva u_sva (
  .clock         (clock),
  .reset         (reset),
  .tok_valid_i   (tok_valid_o),
  .data_valid_i  (data_valid_o),
  .data_tvalid_i (data_tvalid_o)
);

//--- hw/usb_rx_top.sv
`timescale 1ns/1ns

// USB receive front end
// Decoder, token filter and register block
module usb_rx_top (
  input  logic        clock,
  input  logic        reset,
  // PHY byte stream
  input  logic        ulpi_tvalid_i,
  input  logic        ulpi_tlast_i,
  input  logic [7:0]  ulpi_tdata_i,
  output logic        ulpi_tready_o,
  // Wishbone slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  // Filtered events
  output logic        tok_valid_o,
  output logic [1:0]  tok_type_o,
  output logic [3:0]  tok_endp_o,
  output logic        data_valid_o,
  output logic [1:0]  data_type_o,
  output logic        data_tvalid_o,
  output logic        data_tlast_o,
  output logic [7:0]  data_tdata_o,
  output logic        hsk_valid_o,
  output logic [1:0]  hsk_type_o,
  output logic        crc_err_o
);

  // Decoder to filter
  logic        tok_recv;
  logic [1:0]  tok_type;
  logic [6:0]  tok_addr;
  logic [3:0]  tok_endp;
  logic [10:0] token_field;
  logic        sof_recv;
  logic        out_recv;
  logic [1:0]  out_type;
  logic        out_tvalid;
  logic        out_tlast;
  logic [7:0]  out_tdata;
  logic        hsk_recv;
  logic [1:0]  hsk_type;
  logic        crc_err_pulse;

  // Between filter and registers
  logic [6:0]  dev_addr;
  logic        enable;
  logic [10:0] frame;
  logic        frame_load;
  logic        sof_event;

  usb_packet_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .ulpi_tvalid_i (ulpi_tvalid_i),
    .ulpi_tlast_i  (ulpi_tlast_i),
    .ulpi_tdata_i  (ulpi_tdata_i),
    .ulpi_tready_o (ulpi_tready_o),
    .tok_recv_o    (tok_recv),
    .tok_type_o    (tok_type),
    .tok_addr_o    (tok_addr),
    .tok_endp_o    (tok_endp),
    .token_field_o (token_field),
    .sof_recv_o    (sof_recv),
    .out_recv_o    (out_recv),
    .out_type_o    (out_type),
    .out_tvalid_o  (out_tvalid),
    .out_tlast_o   (out_tlast),
    .out_tdata_o   (out_tdata),
    .hsk_recv_o    (hsk_recv),
    .hsk_type_o    (hsk_type),
    .crc_err_o     (crc_err_pulse)
  );

  usb_token_filter u_filter (
    .clock           (clock),
    .reset           (reset),
    .tok_recv_i      (tok_recv),
    .tok_type_i      (tok_type),
    .tok_addr_i      (tok_addr),
    .tok_endp_i      (tok_endp),
    .token_field_i   (token_field),
    .sof_recv_i      (sof_recv),
    .out_recv_i      (out_recv),
    .out_type_i      (out_type),
    .out_tvalid_i    (out_tvalid),
    .out_tlast_i     (out_tlast),
    .out_tdata_i     (out_tdata),
    .hsk_recv_i      (hsk_recv),
    .hsk_type_i      (hsk_type),
    .crc_err_i       (crc_err_pulse),
    .dev_addr_i      (dev_addr),
    .enable_i        (enable),
    .tok_valid_o     (tok_valid_o),
    .tok_type_o      (tok_type_o),
    .tok_endp_o      (tok_endp_o),
    .data_valid_o    (data_valid_o),
    .data_type_o     (data_type_o),
    .data_tvalid_o   (data_tvalid_o),
    .data_tlast_o    (data_tlast_o),
    .data_tdata_o    (data_tdata_o),
    .hsk_valid_o     (hsk_valid_o),
    .hsk_type_o      (hsk_type_o),
    .frame_o         (frame),
    .frame_load_o    (frame_load),
    .sof_event_o     (sof_event),
    .crc_err_event_o (crc_err_o)
  );

  usb_rx_regs u_regs (
    .clock           (clock),
    .reset           (reset),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .frame_i         (frame),
    .frame_load_i    (frame_load),
    .sof_event_i     (sof_event),
    .crc_err_event_i (crc_err_o),
    .dev_addr_o      (dev_addr),
    .enable_o        (enable)
  );

endmodule

//--- hw/usb_rx_regs.sv
`timescale 1ns/1ns

// Wishbone classic register block
// Control register, last frame number and saturating event counters
module usb_rx_regs
  import usb_rx_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // Wishbone slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  // Events from the filter
  input  logic [10:0] frame_i,
  input  logic        frame_load_i,
  input  logic        sof_event_i,
  input  logic        crc_err_event_i,
  // Filter control
  output logic [6:0]  dev_addr_o,
  output logic        enable_o
);

  logic        wb_req;
  logic        wb_wr;
  logic [10:0] frame_q;
  logic [15:0] crc_errs_q;
  logic [15:0] sof_count_q;

  // New request only while no ack is out, so ack is one cycle wide
  assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wb_wr  = wb_req && wb_we_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= wb_req;
    end
  end

  // Control register, address in 6:0 and enable in 7
  always_ff @(posedge clock) begin
    if (reset) begin
      dev_addr_o <= 7'd0;
      enable_o   <= 1'b0;
    end else if (wb_wr && wb_adr_i == reg_ctrl) begin
      dev_addr_o <= wb_dat_i[6:0];
      enable_o   <= wb_dat_i[7];
    end
  end

  // Frame number, read-only
  always_ff @(posedge clock) begin
    if (reset) begin
      frame_q <= 11'd0;
    end else if (frame_load_i) begin
      frame_q <= frame_i;
    end
  end

  // CRC error counter
  // Any write clears it, and the write wins over a same-cycle event
  always_ff @(posedge clock) begin
    if (reset) begin
      crc_errs_q <= 16'd0;
    end else if (wb_wr && wb_adr_i == reg_crc_errs) begin
      crc_errs_q <= 16'd0;
    end else if (crc_err_event_i && !(&crc_errs_q)) begin
      crc_errs_q <= crc_errs_q + 16'd1;
    end
  end

  // SOF counter, same rules
  always_ff @(posedge clock) begin
    if (reset) begin
      sof_count_q <= 16'd0;
    end else if (wb_wr && wb_adr_i == reg_sof_count) begin
      sof_count_q <= 16'd0;
    end else if (sof_event_i && !(&sof_count_q)) begin
      sof_count_q <= sof_count_q + 16'd1;
    end
  end

  // Read data, registered so it is valid with ack
  always_ff @(posedge clock) begin
    if (wb_req) begin
      case (wb_adr_i)
        reg_ctrl:     wb_dat_o <= {24'd0, enable_o, dev_addr_o};
        reg_frame:    wb_dat_o <= {21'd0, frame_q};
        reg_crc_errs: wb_dat_o <= {16'd0, crc_errs_q};
        default:      wb_dat_o <= {16'd0, sof_count_q};
      endcase
    end
  end

endmodule

//--- hw/usb_token_filter.sv
`timescale 1ns/1ns

// Token filter
// Passes tokens for this device and data only after OUT or SETUP
module usb_token_filter
  import usb_rx_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // From the decoder
  input  logic        tok_recv_i,
  input  logic [1:0]  tok_type_i,
  input  logic [6:0]  tok_addr_i,
  input  logic [3:0]  tok_endp_i,
  input  logic [10:0] token_field_i,
  input  logic        sof_recv_i,
  input  logic        out_recv_i,
  input  logic [1:0]  out_type_i,
  input  logic        out_tvalid_i,
  input  logic        out_tlast_i,
  input  logic [7:0]  out_tdata_i,
  input  logic        hsk_recv_i,
  input  logic [1:0]  hsk_type_i,
  input  logic        crc_err_i,
  // From the register block
  input  logic [6:0]  dev_addr_i,
  input  logic        enable_i,
  // Filtered events
  output logic        tok_valid_o,
  output logic [1:0]  tok_type_o,
  output logic [3:0]  tok_endp_o,
  output logic        data_valid_o,
  output logic [1:0]  data_type_o,
  output logic        data_tvalid_o,
  output logic        data_tlast_o,
  output logic [7:0]  data_tdata_o,
  output logic        hsk_valid_o,
  output logic [1:0]  hsk_type_o,
  // To the register block
  output logic [10:0] frame_o,
  output logic        frame_load_o,
  output logic        sof_event_o,
  output logic        crc_err_event_o
);

  logic tok_match;
  // Last accepted token opened a host-to-device data stage
  logic armed;
  logic sof_q;

  assign tok_match = tok_recv_i && enable_i && tok_addr_i == dev_addr_i;

  // Data gate, cleared by any other token or an SOF
  always_ff @(posedge clock) begin
    if (reset) begin
      armed <= 1'b0;
    end else if (tok_match) begin
      armed <= tok_type_i == tok_out || tok_type_i == tok_setup;
    end else if (tok_recv_i || sof_recv_i) begin
      armed <= 1'b0;
    end
  end

  // Strobes, one register stage each
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_valid_o     <= 1'b0;
      data_valid_o    <= 1'b0;
      data_tvalid_o   <= 1'b0;
      data_tlast_o    <= 1'b0;
      hsk_valid_o     <= 1'b0;
      sof_q           <= 1'b0;
      crc_err_event_o <= 1'b0;
    end else begin
      tok_valid_o     <= tok_match;
      data_valid_o    <= out_recv_i && armed;
      data_tvalid_o   <= out_tvalid_i && armed;
      data_tlast_o    <= out_tvalid_i && out_tlast_i && armed;
      hsk_valid_o     <= hsk_recv_i;
      sof_q           <= sof_recv_i;
      crc_err_event_o <= crc_err_i;
    end
  end

  // Field registers follow their strobes
  always_ff @(posedge clock) begin
    if (tok_match) begin
      tok_type_o <= tok_type_i;
      tok_endp_o <= tok_endp_i;
    end
    if (out_recv_i) begin
      data_type_o <= out_type_i;
    end
    if (out_tvalid_i) begin
      data_tdata_o <= out_tdata_i;
    end
    if (hsk_recv_i) begin
      hsk_type_o <= hsk_type_i;
    end
    // SOF token field is the frame number
    if (sof_recv_i) begin
      frame_o <= token_field_i;
    end
  end

  // Every good SOF loads the frame and counts
  assign frame_load_o = sof_q;
  assign sof_event_o  = sof_q;

endmodule

//--- hw/usb_packet_decoder.sv
`timescale 1ns/1ns

// Receive packet decoder
// Checks the PID, sorts packets by class and checks their CRCs
module usb_packet_decoder
  import usb_rx_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // Byte stream from the PHY wrapper
  input  logic        ulpi_tvalid_i,
  input  logic        ulpi_tlast_i,
  input  logic [7:0]  ulpi_tdata_i,
  output logic        ulpi_tready_o,
  // Token and SOF
  output logic        tok_recv_o,
  output logic [1:0]  tok_type_o,
  output logic [6:0]  tok_addr_o,
  output logic [3:0]  tok_endp_o,
  output logic [10:0] token_field_o,
  output logic        sof_recv_o,
  // Data packet start and payload
  output logic        out_recv_o,
  output logic [1:0]  out_type_o,
  output logic        out_tvalid_o,
  output logic        out_tlast_o,
  output logic [7:0]  out_tdata_o,
  // Handshake
  output logic        hsk_recv_o,
  output logic [1:0]  hsk_type_o,
  output logic        crc_err_o
);

  logic [3:0]  pid;
  logic        pid_ok;
  logic        pid_take;
  logic [6:0]  state;
  // Bytes seen after the PID, saturates at 3
  logic [1:0]  byte_cnt;
  logic [1:0]  trn_type_q;
  logic [10:0] token_field_q;
  logic [4:0]  token_crc_q;
  logic        crc5_ok;
  // Two-byte delay line for data packets
  logic [7:0]  rx_buf0;
  logic [7:0]  rx_buf1;
  logic [15:0] crc16_q;
  logic [15:0] crc16_w;
  logic        data_crc_ok;
  logic        payload_take;

  // PHY stream cannot be paused
  assign ulpi_tready_o = 1'b1;

  // PID nibble must match the inverted upper nibble
  assign pid      = ulpi_tdata_i[3:0];
  assign pid_ok   = pid == ~ulpi_tdata_i[7:4];
  assign pid_take = state == st_idle && ulpi_tvalid_i && pid_ok;

  // Token, data and handshake types all share the upper PID bits
  assign tok_type_o    = trn_type_q;
  assign out_type_o    = trn_type_q;
  assign hsk_type_o    = trn_type_q;
  assign tok_addr_o    = token_field_q[6:0];
  assign tok_endp_o    = token_field_q[10:7];
  assign token_field_o = token_field_q;

  // Packet class FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // A PID with last set is a handshake, nothing more to collect
          if (pid_take && !ulpi_tlast_i) begin
            if (pid == pid_sof) begin
              state <= st_sof;
            end else if (pid[1:0] == pid_cls_token) begin
              state <= st_token;
            end else if (pid[1:0] == pid_cls_data) begin
              state <= st_data;
            end
          end
        end
        st_sof: begin
          if (ulpi_tvalid_i && ulpi_tlast_i) begin
            state <= st_sof_crc;
          end
        end
        st_token: begin
          if (ulpi_tvalid_i && ulpi_tlast_i) begin
            state <= st_token_crc;
          end
        end
        st_data: begin
          if (ulpi_tvalid_i && ulpi_tlast_i) begin
            state <= st_data_crc;
          end
        end
        // CRC states last a single cycle
        default: state <= st_idle;
      endcase
    end
  end

  // Byte position within the packet body
  always_ff @(posedge clock) begin
    if (reset || state == st_idle) begin
      byte_cnt <= 2'd0;
    end else if (ulpi_tvalid_i && byte_cnt != 2'd3) begin
      byte_cnt <= byte_cnt + 2'd1;
    end
  end

  // Transaction type from the accepted PID
  always_ff @(posedge clock) begin
    if (pid_take) begin
      trn_type_q <= pid[3:2];
    end
  end

  // Token field capture
  // Byte 0 is field[7:0], byte 1 holds field[10:8] and the CRC5
  always_ff @(posedge clock) begin
    if ((state == st_token || state == st_sof) && ulpi_tvalid_i) begin
      if (byte_cnt == 2'd0) begin
        token_field_q[7:0] <= ulpi_tdata_i;
      end else if (byte_cnt == 2'd1) begin
        token_field_q[10:8] <= ulpi_tdata_i[2:0];
        token_crc_q         <= ulpi_tdata_i[7:3];
      end
    end
  end

  // Token is exactly two bytes after the PID
  assign crc5_ok = byte_cnt == 2'd2 && crc5(token_field_q) == token_crc_q;

  // Delay line, oldest byte in rx_buf1
  always_ff @(posedge clock) begin
    if (ulpi_tvalid_i) begin
      rx_buf1 <= rx_buf0;
      rx_buf0 <= ulpi_tdata_i;
    end
  end

  // Running CRC16 fed from the delay line
  // The final byte is still in rx_buf0 on the CRC state
  assign crc16_w = crc16(rx_buf0, crc16_q);

  always_ff @(posedge clock) begin
    if (state == st_idle) begin
      crc16_q <= crc16_init;
    end else if (state == st_data && ulpi_tvalid_i && byte_cnt != 2'd0) begin
      crc16_q <= crc16_w;
    end
  end

  // Needs at least the two CRC bytes
  assign data_crc_ok = byte_cnt[1] && crc16_w == crc16_residue;

  // Two bytes already buffered, so rx_buf1 is payload and not CRC
  assign payload_take = state == st_data && ulpi_tvalid_i && byte_cnt[1];

  // Payload stream, tlast when the incoming byte closes the packet
  always_ff @(posedge clock) begin
    if (reset) begin
      out_tvalid_o <= 1'b0;
      out_tlast_o  <= 1'b0;
    end else begin
      out_tvalid_o <= payload_take;
      out_tlast_o  <= payload_take && ulpi_tlast_i;
    end
  end

  always_ff @(posedge clock) begin
    if (payload_take) begin
      out_tdata_o <= rx_buf1;
    end
  end

  // Start-of-packet strobes, one edge after the PID
  always_ff @(posedge clock) begin
    if (reset) begin
      out_recv_o <= 1'b0;
      hsk_recv_o <= 1'b0;
    end else begin
      out_recv_o <= pid_take && !ulpi_tlast_i && pid[1:0] == pid_cls_data;
      hsk_recv_o <= pid_take && pid[1:0] == pid_cls_hsk;
    end
  end

  // End-of-packet strobes, registered from the CRC states
  always_ff @(posedge clock) begin
    if (reset) begin
      tok_recv_o <= 1'b0;
      sof_recv_o <= 1'b0;
      crc_err_o  <= 1'b0;
    end else begin
      tok_recv_o <= state == st_token_crc && crc5_ok;
      sof_recv_o <= state == st_sof_crc && crc5_ok;
      crc_err_o  <= ((state == st_token_crc || state == st_sof_crc) && !crc5_ok) ||
                    (state == st_data_crc && !data_crc_ok);
    end
  end

endmodule

//--- hw/usb_rx_pkg.sv
// Shared constants and CRC helpers for the USB receive front end
package usb_rx_pkg;

  // PID codes, lower nibble of the PID byte
  localparam logic [3:0] pid_out   = 4'b0001;
  localparam logic [3:0] pid_in    = 4'b1001;
  localparam logic [3:0] pid_sof   = 4'b0101;
  localparam logic [3:0] pid_setup = 4'b1101;
  localparam logic [3:0] pid_data0 = 4'b0011;
  localparam logic [3:0] pid_data1 = 4'b1011;
  localparam logic [3:0] pid_data2 = 4'b0111;
  localparam logic [3:0] pid_mdata = 4'b1111;
  localparam logic [3:0] pid_ack   = 4'b0010;
  localparam logic [3:0] pid_nak   = 4'b1010;
  localparam logic [3:0] pid_stall = 4'b1110;
  localparam logic [3:0] pid_nyet  = 4'b0110;

  // Packet class, lower two PID bits
  localparam logic [1:0] pid_cls_token = 2'b01;
  localparam logic [1:0] pid_cls_data  = 2'b11;
  localparam logic [1:0] pid_cls_hsk   = 2'b10;

  // Transaction type, upper two PID bits of a token
  localparam logic [1:0] tok_out   = 2'b00;
  localparam logic [1:0] tok_sof   = 2'b01;
  localparam logic [1:0] tok_in    = 2'b10;
  localparam logic [1:0] tok_setup = 2'b11;

  // One-hot decoder states
  localparam logic [6:0] st_idle      = 7'b0000001;
  localparam logic [6:0] st_sof       = 7'b0000010;
  localparam logic [6:0] st_sof_crc   = 7'b0000100;
  localparam logic [6:0] st_token     = 7'b0001000;
  localparam logic [6:0] st_token_crc = 7'b0010000;
  localparam logic [6:0] st_data      = 7'b0100000;
  localparam logic [6:0] st_data_crc  = 7'b1000000;

  // CRC polynomials, seeds and the CRC16 check value
  localparam logic [4:0]  crc5_poly     = 5'h05;
  localparam logic [4:0]  crc5_init     = 5'h1f;
  localparam logic [15:0] crc16_poly    = 16'h8005;
  localparam logic [15:0] crc16_init    = 16'hffff;
  localparam logic [15:0] crc16_residue = 16'h800d;

  // Wishbone word addresses
  localparam logic [1:0] reg_ctrl      = 2'd0;
  localparam logic [1:0] reg_frame     = 2'd1;
  localparam logic [1:0] reg_crc_errs  = 2'd2;
  localparam logic [1:0] reg_sof_count = 2'd3;

  // CRC5 over the 11-bit token field, field bit 0 first on the wire
  // Result is inverted and bit-reversed, as it lands in byte bits 7:3
  function automatic logic [4:0] crc5(input logic [10:0] field);
    logic [4:0] crc;
    logic [4:0] result;
    logic       fb;
    crc = crc5_init;
    for (int i = 0; i < 11; i++) begin
      fb  = crc[4] ^ field[i];
      crc = {crc[3:0], 1'b0};
      if (fb) begin
        crc = crc ^ crc5_poly;
      end
    end
    for (int i = 0; i < 5; i++) begin
      result[i] = ~crc[4-i];
    end
    return result;
  endfunction

  // CRC16 update with one byte, LSB first
  function automatic logic [15:0] crc16(input logic [7:0] data, input logic [15:0] crc_in);
    logic [15:0] crc;
    logic        fb;
    crc = crc_in;
    for (int i = 0; i < 8; i++) begin
      fb  = crc[15] ^ data[i];
      crc = {crc[14:0], 1'b0};
      if (fb) begin
        crc = crc ^ crc16_poly;
      end
    end
    return crc;
  endfunction

endpackage
